//--- design/video_pkg.sv
// shared constants and types for the 720p flag DVI pipeline
// imported by the timing, painter, encoder and top modules

package video_pkg;

    // 720p raster, positive sync polarity
    localparam int h_active = 1280;
    localparam int h_front  = 110;
    localparam int h_sync   = 40;
    localparam int h_back   = 220;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 1650
    localparam int v_active = 720;
    localparam int v_front  = 5;
    localparam int v_sync   = 5;
    localparam int v_back   = 20;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 750

    localparam int hs_start = h_active + h_front;     // 1390
    localparam int hs_end   = hs_start + h_sync - 1;  // 1429
    localparam int vs_start = v_active + v_front;     // 725
    localparam int vs_end   = vs_start + v_sync - 1;  // 729

    localparam int cord_w = 12;   // sx/sy counter width
    localparam int band_h = 240;  // lines per flag band

    // 4-bit palette entry, r g b order
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_t;

    localparam pal_t pal_green  = '{r: 4'h0, g: 4'h9, b: 4'h3};
    localparam pal_t pal_yellow = '{r: 4'hF, g: 4'hE, b: 4'h1};
    localparam pal_t pal_red    = '{r: 4'hE, g: 4'h1, b: 4'h2};

    // tmds control symbols indexed by {c1, c0}
    localparam logic [3:0][9:0] tmds_ctrl = {
        10'b1010101011,  // 11
        10'b0101010100,  // 10
        10'b0010101011,  // 01
        10'b1101010100   // 00
    };

    localparam int paint_lat = 1;  // flag_painter latency
    localparam int enc_lat   = 2;  // tmds_encoder latency

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // ch0 blue, ch1 green, ch2 red
    typedef struct packed {
        logic [9:0] ch2;
        logic [9:0] ch1;
        logic [9:0] ch0;
    } tmds_pix_t;

endpackage

//--- design/pipe_delay.sv
// fixed delay line for any packed payload, used to keep side signals
// in step with a datapath of known latency

`timescale 1ns/1ps

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk_pix,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [depth];  // stage[0] is the newest sample

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) stage[i] <= '0;
        end else begin
            stage[0] <= din;
            for (int i = 1; i < depth; i++) stage[i] <= stage[i-1];
        end
    end

    assign dout = stage[depth-1];  // last stage out

endmodule

//--- design/display_timing.sv
// 1280x720 display timing, counters plus positive hsync/vsync and de
// outputs are all registered so coordinates and sync line up

`timescale 1ns/1ps

module display_timing import video_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst_n,
    output logic [cord_w-1:0] sx,
    output logic [cord_w-1:0] sy,
    output sync_t             sync
);

    logic [cord_w-1:0] x;  // free running horizontal count
    logic [cord_w-1:0] y;  // free running vertical count
    sync_t             sync_next;

    // raster counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (x == cord_w'(h_total - 1)) begin
            x <= '0;  // end of line
            if (y == cord_w'(v_total - 1)) begin
                y <= '0;  // end of frame
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // sync and de decode from the current count
    always_comb begin
        sync_next.hsync = (x >= cord_w'(hs_start)) && (x <= cord_w'(hs_end));
        sync_next.vsync = (y >= cord_w'(vs_start)) && (y <= cord_w'(vs_end));
        sync_next.de    = (x < cord_w'(h_active)) && (y < cord_w'(v_active));
    end

    // coordinates and sync registered on the same edge
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx   <= '0;
            sy   <= '0;
            sync <= '0;
        end else begin
            sx   <= x;
            sy   <= y;
            sync <= sync_next;
        end
    end

endmodule

//--- design/flag_painter.sv
// colour lookup for the three-band flag, one cycle from sy/de to rgb
// black outside the active area, nibbles doubled up to 8 bits

`timescale 1ns/1ps

module flag_painter import video_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic [cord_w-1:0] sy,
    input  logic              de,
    output rgb_t              rgb
);

    pal_t paint;  // band colour for this line
    pal_t shown;  // after blanking

    // pick the band by line number
    always_comb begin
        if (sy < cord_w'(band_h)) begin
            paint = pal_green;   // top band
        end else if (sy < cord_w'(2 * band_h)) begin
            paint = pal_yellow;  // middle band
        end else begin
            paint = pal_red;     // bottom band
        end
    end

    // black in blanking so the encoder sees zero data
    always_comb begin
        shown = de ? paint : '0;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else begin
            rgb.r <= {2{shown.r}};  // 4 to 8 bits by repeating the nibble
            rgb.g <= {2{shown.g}};
            rgb.b <= {2{shown.b}};
        end
    end

endmodule

//--- design/tmds_encoder.sv
// tmds 8b/10b encoder for one dvi channel with two register stages
// emits control symbols while de is low and clears the disparity there

`timescale 1ns/1ps

module tmds_encoder import video_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic [7:0] data,
    input  logic [1:0] ctrl,
    input  logic       de,
    output logic [9:0] tmds
);

    // control side carried alongside q_m
    typedef struct packed {
        logic       de;
        logic [1:0] ctrl;
    } enc_ctl_t;

    enc_ctl_t          ctl_in;
    enc_ctl_t          ctl_d;     // aligned with q_m
    logic [3:0]        n1_d;      // ones in data
    logic              use_xnor;
    logic [8:0]        qm_next;
    logic [8:0]        q_m;       // transition minimised word
    logic [3:0]        n1_q;      // ones in q_m[7:0]
    logic signed [5:0] bal;       // ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;      // running disparity
    logic signed [5:0] disp_next;
    logic [9:0]        tmds_next;

    function automatic logic [3:0] ones8(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) n = n + {3'b000, v[i]};
        return n;
    endfunction

    assign ctl_in = '{de: de, ctrl: ctrl};

    pipe_delay #(
        .payload_t (enc_ctl_t),
        .depth     (1)
    ) ctl_delay_inst (
        .clk_pix,
        .rst_n,
        .din  (ctl_in),
        .dout (ctl_d)
    );

    // stage one builds q_m with an xor or xnor chain
    always_comb begin
        n1_d     = ones8(data);
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);
        qm_next[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            qm_next[i] = use_xnor ? ~(qm_next[i-1] ^ data[i]) : (qm_next[i-1] ^ data[i]);
        end
        qm_next[8] = ~use_xnor;  // 1 marks xor
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            q_m <= '0;
        end else begin
            q_m <= qm_next;  // lines up with ctl_d
        end
    end

    // stage two does the dc balancing
    always_comb begin
        n1_q = ones8(q_m[7:0]);
        bal  = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;  // 2*n1 - 8
        if (!ctl_d.de) begin
            tmds_next = tmds_ctrl[ctl_d.ctrl];
            disp_next = '0;  // blanking restarts the balance
        end else if ((disp == 6'sd0) || (bal == 6'sd0)) begin
            // no bias either way so bit 9 simply flags the xor/xnor choice
            tmds_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + bal : disp - bal;
        end else if (((disp > 6'sd0) && (bal > 6'sd0)) ||
                     ((disp < 6'sd0) && (bal < 6'sd0))) begin
            tmds_next = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull back
            disp_next = disp + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            tmds_next = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            tmds <= tmds_ctrl[0];  // idle control symbol
            disp <= '0;
        end else begin
            tmds <= tmds_next;
            disp <= disp_next;
        end
    end

endmodule

//--- design/dvi_top.sv
// pixel clock side of the dvi flag output
// three parallel tmds symbols per clk_pix, serializers live outside

`timescale 1ns/1ps

module dvi_top import video_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst_n,
    output tmds_pix_t tmds
);

    logic [cord_w-1:0] sy;
    sync_t             sync_raw;  // from the timing generator
    sync_t             sync_d;    // lined up with rgb
    rgb_t              rgb;

    display_timing timing_inst (
        .clk_pix,
        .rst_n,
        .sx   (),  // flag bands depend on the line only
        .sy,
        .sync (sync_raw)
    );

    flag_painter painter_inst (
        .clk_pix,
        .rst_n,
        .sy,
        .de  (sync_raw.de),
        .rgb
    );

    pipe_delay #(
        .payload_t (sync_t),
        .depth     (paint_lat)
    ) sync_delay_inst (
        .clk_pix,
        .rst_n,
        .din  (sync_raw),
        .dout (sync_d)
    );

    // blue carries the sync controls
    tmds_encoder enc_ch0_inst (
        .clk_pix,
        .rst_n,
        .data (rgb.b),
        .ctrl ({sync_d.vsync, sync_d.hsync}),
        .de   (sync_d.de),
        .tmds (tmds.ch0)
    );

    tmds_encoder enc_ch1_inst (
        .clk_pix,
        .rst_n,
        .data (rgb.g),
        .ctrl (2'b00),
        .de   (sync_d.de),
        .tmds (tmds.ch1)
    );

    tmds_encoder enc_ch2_inst (
        .clk_pix,
        .rst_n,
        .data (rgb.r),
        .ctrl (2'b00),
        .de   (sync_d.de),
        .tmds (tmds.ch2)
    );

endmodule

//--- verif/tb_clock.sv
// clock and power-on reset for the dvi testbench
// 10 ns clk_pix, rst_n held low for the first 16 rising edges

`timescale 1ns/1ps

module tb_clock (
    output logic clk_pix,
    output logic rst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk_pix);
        rst_n <= 1'b1;  // release lands on a rising edge
    end

endmodule

//--- verif/dvi_sva.sv
// concurrent checks bound into every instance of the tmds encoder
// watches control symbol insertion and the running disparity

`timescale 1ns/1ps

module dvi_sva import video_pkg::*; (
    input logic              clk_pix,
    input logic              rst_n,
    input logic              de,
    input logic [9:0]        tmds,
    input logic signed [5:0] disp
);

    int fail_count = 0;  // assertion failures in this instance

    // blanking shows up as a control symbol after the two stage latency
    a_ctrl_symbol: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |-> ##2 (tmds == tmds_ctrl[0] || tmds == tmds_ctrl[1] ||
                     tmds == tmds_ctrl[2] || tmds == tmds_ctrl[3]))
        else begin
            fail_count++;
            $error("no control symbol two cycles after de low");
        end

    // dc balance bound
    a_disp_bound: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (disp <= 6'sd10) && (disp >= -6'sd10))
        else begin
            fail_count++;
            $error("running disparity beyond 10");
        end

    a_disp_clear: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |-> ##2 (disp == 6'sd0))  // cleared while blanking
        else begin
            fail_count++;
            $error("running disparity not cleared in blanking");
        end

endmodule

bind tmds_encoder dvi_sva sva_inst (
    .clk_pix (clk_pix),
    .rst_n   (rst_n),
    .de      (de),
    .tmds    (tmds),
    .disp    (disp)
);

//--- verif/dvi_tb.sv
// directed testbench for the dvi flag pipeline
// decodes the tmds symbols and compares them with a raster model started after reset

`timescale 1ns/1ps

module dvi_tb import video_pkg::*; ();

    logic      clk_pix;
    logic      por_n;    // power-on reset from the clock source
    logic      pulse_n;  // extra reset pulse driven by the tests
    logic      rst_n;
    tmds_pix_t tmds;
    int        exp_sx;   // raster position now on the outputs
    int        exp_sy;
    int        errors;

    tb_clock clock_inst (.clk_pix, .rst_n (por_n));

    assign rst_n = por_n & pulse_n;

    dvi_top dvi_top_inst (.clk_pix, .rst_n, .tmds);

    function automatic logic [7:0] decode_tmds(input logic [9:0] sym);
        logic [7:0] d;
        logic [7:0] v;
        d = sym[9] ? ~sym[7:0] : sym[7:0];  // undo dc inversion
        v[0] = d[0];
        for (int i = 1; i < 8; i++) v[i] = sym[8] ? d[i] ^ d[i-1] : ~(d[i] ^ d[i-1]);
        return v;
    endfunction

    function automatic pal_t band_colour(input int line);
        if (line < band_h) return pal_green;
        if (line < 2 * band_h) return pal_yellow;
        return pal_red;
    endfunction

    function automatic int ones_minus_zeros(input logic [9:0] sym);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++) n += sym[i] ? 1 : -1;
        return n;
    endfunction

    // failures counted by the bound encoder checkers
    function automatic int assertion_failures();
        return dvi_top_inst.enc_ch0_inst.sva_inst.fail_count
             + dvi_top_inst.enc_ch1_inst.sva_inst.fail_count
             + dvi_top_inst.enc_ch2_inst.sva_inst.fail_count;
    endfunction

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $fatal(1, "wait timed out");
    endtask

    // steps one clock and samples outputs on the falling edge
    task automatic advance();
        @(negedge clk_pix);
        exp_sx++;
        if (exp_sx == h_total) begin
            exp_sx = 0;
            exp_sy = (exp_sy == v_total - 1) ? 0 : exp_sy + 1;
        end
    endtask

    task automatic run_to(input int x, input int y);
        int waited;
        waited = 0;
        while (exp_sx != x || exp_sy != y) begin
            advance();
            waited++;
            if (waited > h_total * v_total) report_timeout("raster position never reached");
        end
    endtask

    task automatic check_idle();
        check_value("ch0 idle", tmds_ctrl[0], tmds.ch0);
        check_value("ch1 idle", tmds_ctrl[0], tmds.ch1);
        check_value("ch2 idle", tmds_ctrl[0], tmds.ch2);
    endtask

    // expected symbol class from the model position
    task automatic check_pixel();
        pal_t       p;
        logic [1:0] c;
        string      at;
        at = $sformatf(" at (%0d,%0d)", exp_sx, exp_sy);
        if (exp_sx < h_active && exp_sy < v_active) begin
            p = band_colour(exp_sy);
            check_value({"ch2 red", at}, {2{p.r}}, decode_tmds(tmds.ch2));
            check_value({"ch1 green", at}, {2{p.g}}, decode_tmds(tmds.ch1));
            check_value({"ch0 blue", at}, {2{p.b}}, decode_tmds(tmds.ch0));
        end else begin
            c[0] = (exp_sx >= hs_start) && (exp_sx <= hs_end);  // hsync
            c[1] = (exp_sy >= vs_start) && (exp_sy <= vs_end);  // vsync
            check_value({"ch0 control", at}, tmds_ctrl[c], tmds.ch0);
            check_value({"ch1 control", at}, tmds_ctrl[0], tmds.ch1);
            check_value({"ch2 control", at}, tmds_ctrl[0], tmds.ch2);
        end
    endtask

    // idle while in reset, then for the pipeline latency, then pixel (0,0)
    task automatic follow_reset_release();
        int waited;
        waited = 0;
        @(negedge clk_pix);
        while (!rst_n) begin
            check_idle();
            @(negedge clk_pix);
            waited++;
            if (waited > 64) report_timeout("rst_n never went high");
        end
        repeat (paint_lat + enc_lat + 1) begin
            check_idle();
            @(negedge clk_pix);
        end
        exp_sx = 0;
        exp_sy = 0;
    endtask

    task automatic test_reset_state();
        @(posedge clk_pix);
        pulse_n <= 1'b0;
        repeat (5) begin
            @(negedge clk_pix);
            check_idle();
        end
        @(posedge clk_pix);
        pulse_n <= 1'b1;
        follow_reset_release();
        check_pixel();  // green again at the top left
    endtask

    task automatic test_active_colours();
        int lines[6] = '{0, 239, 240, 479, 480, 719};
        int cols[3]  = '{0, 640, 1279};
        foreach (lines[i]) begin
            foreach (cols[j]) begin
                run_to(cols[j], lines[i]);
                check_pixel();
            end
        end
    endtask

    task automatic test_hblank();
        run_to(h_active, v_active - 1);  // last visible line
        repeat (h_total - h_active) begin
            check_pixel();
            advance();
        end
    endtask

    task automatic test_vsync();
        int vs_seen;
        vs_seen = 0;
        run_to(0, 0);
        repeat (h_total * v_total) begin
            check_pixel();
            if (tmds.ch0 == tmds_ctrl[2] || tmds.ch0 == tmds_ctrl[3]) vs_seen++;
            advance();
        end
        check_value("vsync symbols per frame", v_sync * h_total, vs_seen);
        check_pixel();  // next frame opens green
    endtask

    task automatic test_dc_balance();
        int         tally[3];
        logic [9:0] sym;
        for (int y = 0; y < v_active; y++) begin
            run_to(0, y);
            tally = '{0, 0, 0};  // blanking clears the encoder balance
            repeat (h_active) begin
                for (int c = 0; c < 3; c++) begin
                    sym = (c == 0) ? tmds.ch0 : (c == 1) ? tmds.ch1 : tmds.ch2;
                    tally[c] += ones_minus_zeros(sym);
                    if (tally[c] > 10 || tally[c] < -10) begin
                        check_value($sformatf("ch%0d disparity on line %0d", c, y),
                                    tally[c] > 0 ? 10 : -10, tally[c]);
                    end
                end
                advance();
            end
        end
    endtask

    initial begin
        pulse_n = 1'b1;
        errors  = 0;
        exp_sx  = 0;
        exp_sy  = 0;
        follow_reset_release();
        test_active_colours();
        test_hblank();
        test_vsync();
        test_dc_balance();
        test_reset_state();
        check_value("assertion failures", 0, assertion_failures());
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/video_pkg.sv
design/pipe_delay.sv
design/display_timing.sv
design/flag_painter.sv
design/tmds_encoder.sv
design/dvi_top.sv
verif/tb_clock.sv
verif/dvi_sva.sv
verif/dvi_tb.sv
